// File: adc_acq_pkg.sv
`default_nettype none

package adc_acq_pkg;

    //////////////////////////////////////////////////
    // sample and pair widths
    localparam int SAMPLE_W       = 12;      // one adc sample
    localparam int PAIR_W         = 26;      // {smp1, ovr1, smp0, ovr0}
    localparam int PAIRS_PER_WORD = 4;       // eight samples per data word

    typedef logic [PAIR_W-1:0] pair_t;

    //////////////////////////////////////////////////
    // output word
    localparam int OUT_W      = 132;         // tag plus body
    localparam int BODY_W     = 128;
    localparam int FILL_NUM_W = 24;
    localparam int BURST_W    = 14;          // burst count width
    localparam int CHAN_TAG_W = 12;
    localparam int PRE_TRIG_W = 16;

    typedef enum logic [3:0] {
        TAG_FILL_HDR = 4'h1,                 // fill header word
        TAG_DATA     = 4'h2                  // four packed pairs
    } out_tag_e;

    // fill header body layout, unlisted bits stay zero
    localparam int HDR_FILL_LSB  = 0;        // 23:0
    localparam int HDR_TAG_LSB   = 24;       // 35:24
    localparam int HDR_BURST_LSB = 36;       // 49:36
    localparam int HDR_PRE_LSB   = 50;       // 65:50

endpackage

`default_nettype wire

// File: acq_input_sync.sv
`timescale 1ns/1ps
`default_nettype none

module acq_input_sync (
    input  logic adc_clk,
    input  logic rst_n,
    input  logic acq_enable0,
    input  logic acq_enable1,
    input  logic acq_trig,
    input  logic initial_fill_num_wr,
    output logic wr_en,                // synced enable level, also acq_enabled
    output logic trig_pulse,           // one clock per trigger edge
    output logic fill_num_load         // one clock per fill number write
);

    logic en_s1;
    logic trig_s1, trig_s2, trig_s3;
    logic fnw_s1, fnw_s2, fnw_s3;

    //////////////////////////////////////////////////
    // two-flop synchronizers and edge history
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            en_s1      <= 1'b0;
            wr_en      <= 1'b0;
            trig_s1    <= 1'b0;
            trig_s2    <= 1'b0;
            trig_s3    <= 1'b0;
            trig_pulse <= 1'b0;
            fnw_s1     <= 1'b0;
            fnw_s2     <= 1'b0;
            fnw_s3     <= 1'b0;
        end else begin
            en_s1      <= acq_enable0 | acq_enable1;  // fill type ignored, either one enables
            wr_en      <= en_s1;
            trig_s1    <= acq_trig;
            trig_s2    <= trig_s1;
            trig_s3    <= trig_s2;                     // previous value for edge detect
            trig_pulse <= trig_s2 & ~trig_s3 & wr_en;  // triggers only count while acquiring
            fnw_s1     <= initial_fill_num_wr;
            fnw_s2     <= fnw_s1;
            fnw_s3     <= fnw_s2;
        end
    end

    assign fill_num_load = fnw_s2 & ~fnw_s3;  // rising edge of synced strobe

endmodule

`default_nettype wire

// File: sample_source.sv
`timescale 1ns/1ps
`default_nettype none

module sample_source #(
    parameter int CBUF_AW = 16
) (
    input  logic                              adc_clk,
    input  logic                              rst_n,
    input  logic                              wr_en,
    input  logic                              use_dummy,   // channel_tag[3]
    input  logic [adc_acq_pkg::SAMPLE_W-1:0]  adc_dat_a,
    input  logic [adc_acq_pkg::SAMPLE_W-1:0]  adc_dat_b,
    input  logic                              adc_ovr_a,
    input  logic                              adc_ovr_b,
    output adc_acq_pkg::pair_t                wr_pair,
    output logic [CBUF_AW-1:0]                wr_addr
);

    logic [adc_acq_pkg::SAMPLE_W-1:0] dat_a_q, dat_b_q;
    logic                             ovr_a_q, ovr_b_q;
    logic [adc_acq_pkg::SAMPLE_W-2:0] dummy_n;   // pair counter, samples are 2n and 2n+1

    // pin capture register
    always_ff @(posedge adc_clk) begin
        dat_a_q <= adc_dat_a;
        dat_b_q <= adc_dat_b;
        ovr_a_q <= adc_ovr_a;
        ovr_b_q <= adc_ovr_b;
    end

    //////////////////////////////////////////////////
    // write address and dummy counter, both idle at zero when not acquiring
    always_ff @(posedge adc_clk) begin
        if (!rst_n || !wr_en) begin
            wr_addr <= '0;
            dummy_n <= '0;
        end else begin
            wr_addr <= wr_addr + 1'b1;   // wraps at buffer depth
            dummy_n <= dummy_n + 1'b1;   // one step per written pair
        end
    end

    // pack pair, first sample in the low half
    assign wr_pair = use_dummy ? {dummy_n, 1'b1, 1'b0, dummy_n, 1'b0, 1'b0}
                               : {dat_b_q, ovr_b_q, dat_a_q, ovr_a_q};

    a_wr_addr_known: assert property (@(posedge adc_clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_addr));

endmodule

`default_nettype wire

// File: circ_buf_ram.sv
`timescale 1ns/1ps
`default_nettype none

module circ_buf_ram #(
    parameter int CBUF_AW = 16
) (
    input  logic                 adc_clk,
    input  logic                 we,
    input  logic [CBUF_AW-1:0]   wr_addr,
    input  logic [CBUF_AW-1:0]   rd_addr,
    input  adc_acq_pkg::pair_t   wr_pair,
    output adc_acq_pkg::pair_t   rd_pair
);

    localparam int DEPTH = 1 << CBUF_AW;

    adc_acq_pkg::pair_t mem [DEPTH];   // one pair per location

    // write port
    always_ff @(posedge adc_clk) begin
        if (we) mem[wr_addr] <= wr_pair;
    end

    // read port, one clock latency
    always_ff @(posedge adc_clk) begin
        rd_pair <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: trig_addr_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module trig_addr_fifo #(
    parameter int FIFO_AW = 3,
    parameter int CBUF_AW = 16
) (
    input  logic               adc_clk,
    input  logic               rst_n,
    input  logic               push,      // trig_pulse
    input  logic               pop,
    input  logic [CBUF_AW-1:0] din,       // write address at the trigger
    output logic [CBUF_AW-1:0] head,      // oldest entry, valid while not empty
    output logic               empty
);

    localparam int DEPTH = 1 << FIFO_AW;

    logic [CBUF_AW-1:0] mem [DEPTH];
    logic [FIFO_AW-1:0] wr_ptr, rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               do_push, do_pop;

    assign full    = (count == DEPTH[FIFO_AW:0]);
    assign empty   = (count == '0);
    assign do_push = push & ~full;   // trigger lost when full
    assign do_pop  = pop & ~empty;
    assign head    = mem[rd_ptr];    // fall-through output

    always_ff @(posedge adc_clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

    //////////////////////////////////////////////////
    // pointers and occupancy
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + do_push - do_pop;
        end
    end

    a_no_push_full: assert property (@(posedge adc_clk) disable iff (!rst_n) !(push && full));
    a_no_pop_empty: assert property (@(posedge adc_clk) disable iff (!rst_n) !(pop && empty));

endmodule

`default_nettype wire

// File: readout_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module readout_ctrl #(
    parameter int CBUF_AW = 16
) (
    input  logic                                  adc_clk,
    input  logic                                  rst_n,
    input  logic                                  fifo_empty,
    input  logic [CBUF_AW-1:0]                    trig_addr,
    input  logic [adc_acq_pkg::PRE_TRIG_W-1:0]    pre_trig,
    input  logic [adc_acq_pkg::BURST_W-1:0]       num_bursts,
    input  logic [adc_acq_pkg::FILL_NUM_W-1:0]    initial_fill_num,
    input  logic                                  fill_num_load,
    output logic                                  fifo_pop,
    output logic [CBUF_AW-1:0]                    rd_addr,
    output logic                                  gather,      // rd_pair valid, shift it in
    output logic                                  sel_hdr,
    output logic                                  out_valid,
    output logic [adc_acq_pkg::FILL_NUM_W-1:0]    fill_num,
    output logic                                  acq_done,
    output logic                                  sm_idle
);

    typedef enum logic [2:0] {
        S_IDLE,     // wait for a trigger address
        S_START,    // pop and load start address
        S_HEADER,   // fill header goes out
        S_READ,     // four reads per word
        S_LAST      // last pair of the word comes back
    } state_t;

    state_t                             state;
    logic [adc_acq_pkg::BURST_W-1:0]    burst_cnt;   // words still to send
    logic [1:0]                         pair_cnt;    // reads within a word
    logic                               word_done;   // word complete in the shift register
    logic                               last_word;

    //////////////////////////////////////////////////
    // fill state machine
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            rd_addr   <= '0;
            burst_cnt <= '0;
            pair_cnt  <= '0;
        end else begin
            case (state)
                S_IDLE: if (!fifo_empty) state <= S_START;
                S_START: begin
                    rd_addr   <= trig_addr - pre_trig[CBUF_AW-1:0];  // wraps modulo depth
                    burst_cnt <= num_bursts;
                    pair_cnt  <= '0;
                    state     <= S_HEADER;
                end
                S_HEADER: state <= S_READ;
                S_READ: begin
                    rd_addr  <= rd_addr + 1'b1;
                    pair_cnt <= pair_cnt + 1'b1;
                    if (pair_cnt == 2'(adc_acq_pkg::PAIRS_PER_WORD - 1)) state <= S_LAST;
                end
                S_LAST: begin
                    burst_cnt <= burst_cnt - 1'b1;
                    state     <= (burst_cnt <= 1) ? S_IDLE : S_READ;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // output strobes, registered to line up with the read latency
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            gather    <= 1'b0;
            word_done <= 1'b0;
            last_word <= 1'b0;
            acq_done  <= 1'b0;
        end else begin
            gather    <= (state == S_READ);
            word_done <= (state == S_LAST);
            last_word <= (state == S_LAST) && (burst_cnt <= 1);
            acq_done  <= last_word;   // same cycle as the last word at the top
        end
    end

    assign fifo_pop  = (state == S_START);
    assign sel_hdr   = (state == S_HEADER);
    assign out_valid = sel_hdr | word_done;
    assign sm_idle   = (state == S_IDLE) & ~last_word & ~acq_done;

    //////////////////////////////////////////////////
    // fill number
    always_ff @(posedge adc_clk) begin
        if (!rst_n)             fill_num <= '0;
        else if (fill_num_load) fill_num <= initial_fill_num;
        else if (acq_done)      fill_num <= fill_num + 1'b1;   // next fill
    end

    a_hdr_not_gather: assert property (@(posedge adc_clk) disable iff (!rst_n)
        !(sel_hdr && gather));

endmodule

`default_nettype wire

// File: word_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module word_assembler (
    input  logic                                  adc_clk,
    input  logic                                  rst_n,
    input  adc_acq_pkg::pair_t                    rd_pair,
    input  logic                                  gather,
    input  logic                                  sel_hdr,
    input  logic                                  out_valid,
    input  logic [adc_acq_pkg::FILL_NUM_W-1:0]    fill_num,
    input  logic [adc_acq_pkg::CHAN_TAG_W-1:0]    channel_tag,
    input  logic [adc_acq_pkg::BURST_W-1:0]       num_bursts,
    input  logic [adc_acq_pkg::PRE_TRIG_W-1:0]    pre_trig,
    output logic [adc_acq_pkg::OUT_W-1:0]         adc_acq_out_dat,
    output logic                                  adc_acq_out_valid
);

    adc_acq_pkg::pair_t                sr [adc_acq_pkg::PAIRS_PER_WORD];  // [0] is oldest
    logic [adc_acq_pkg::BODY_W-1:0]    hdr_body;
    logic [adc_acq_pkg::BODY_W-1:0]    dat_body;

    // shift register, new pair enters at the top
    always_ff @(posedge adc_clk) begin
        if (gather) begin
            for (int i = 0; i < adc_acq_pkg::PAIRS_PER_WORD - 1; i++) sr[i] <= sr[i+1];
            sr[adc_acq_pkg::PAIRS_PER_WORD-1] <= rd_pair;
        end
    end

    //////////////////////////////////////////////////
    // header and data bodies
    always_comb begin
        hdr_body = '0;
        hdr_body[adc_acq_pkg::HDR_FILL_LSB  +: adc_acq_pkg::FILL_NUM_W] = fill_num;
        hdr_body[adc_acq_pkg::HDR_TAG_LSB   +: adc_acq_pkg::CHAN_TAG_W] = channel_tag;
        hdr_body[adc_acq_pkg::HDR_BURST_LSB +: adc_acq_pkg::BURST_W]    = num_bursts;
        hdr_body[adc_acq_pkg::HDR_PRE_LSB   +: adc_acq_pkg::PRE_TRIG_W] = pre_trig;
        dat_body = '0;   // top 24 bits stay zero
        for (int i = 0; i < adc_acq_pkg::PAIRS_PER_WORD; i++) begin
            dat_body[i*adc_acq_pkg::PAIR_W +: adc_acq_pkg::PAIR_W] = sr[i];
        end
    end

    // output word register
    always_ff @(posedge adc_clk) begin
        if (out_valid) begin
            adc_acq_out_dat <= sel_hdr ? {adc_acq_pkg::TAG_FILL_HDR, hdr_body}
                                       : {adc_acq_pkg::TAG_DATA, dat_body};
        end
    end

    always_ff @(posedge adc_clk) begin
        if (!rst_n) adc_acq_out_valid <= 1'b0;
        else        adc_acq_out_valid <= out_valid;   // single pulse per word
    end

endmodule

`default_nettype wire

// File: adc_acq_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_acq_top #(
    parameter int CBUF_AW = 16,   // circular buffer address width
    parameter int FIFO_AW = 3     // trigger fifo address width
) (
    input  logic                                  adc_clk,
    input  logic                                  rst_n,
    input  logic [adc_acq_pkg::SAMPLE_W-1:0]      adc_dat_a,
    input  logic [adc_acq_pkg::SAMPLE_W-1:0]      adc_dat_b,
    input  logic                                  adc_ovr_a,
    input  logic                                  adc_ovr_b,
    input  logic [adc_acq_pkg::CHAN_TAG_W-1:0]    channel_tag,
    input  logic [adc_acq_pkg::FILL_NUM_W-1:0]    initial_fill_num,
    input  logic                                  initial_fill_num_wr,
    input  logic                                  acq_enable0,
    input  logic                                  acq_enable1,
    input  logic                                  acq_trig,
    input  logic [adc_acq_pkg::BURST_W-1:0]       async_num_bursts,
    input  logic [adc_acq_pkg::PRE_TRIG_W-1:0]    async_pre_trig,
    output logic                                  acq_enabled,
    output logic [adc_acq_pkg::FILL_NUM_W-1:0]    fill_num,
    output logic [adc_acq_pkg::OUT_W-1:0]         adc_acq_out_dat,
    output logic                                  adc_acq_out_valid,
    output logic                                  acq_done,
    output logic                                  adc_acq_sm_idle
);

    logic                wr_en, trig_pulse, fill_num_load;
    adc_acq_pkg::pair_t  wr_pair, rd_pair;
    logic [CBUF_AW-1:0]  wr_addr, rd_addr, trig_addr;
    logic                fifo_empty, fifo_pop;
    logic                gather, sel_hdr, out_valid;

    assign acq_enabled = wr_en;

    //////////////////////////////////////////////////
    // acquisition side
    acq_input_sync u_sync (
        .adc_clk, .rst_n, .acq_enable0, .acq_enable1, .acq_trig, .initial_fill_num_wr,
        .wr_en, .trig_pulse, .fill_num_load
    );

    sample_source #(.CBUF_AW(CBUF_AW)) u_src (
        .adc_clk, .rst_n, .wr_en,
        .use_dummy (channel_tag[3]),   // 1 = counter data
        .adc_dat_a, .adc_dat_b, .adc_ovr_a, .adc_ovr_b,
        .wr_pair, .wr_addr
    );

    circ_buf_ram #(.CBUF_AW(CBUF_AW)) u_cbuf (
        .adc_clk, .we(wr_en), .wr_addr, .rd_addr, .wr_pair, .rd_pair
    );

    trig_addr_fifo #(.FIFO_AW(FIFO_AW), .CBUF_AW(CBUF_AW)) u_tfifo (
        .adc_clk, .rst_n, .push(trig_pulse), .pop(fifo_pop), .din(wr_addr),
        .head(trig_addr), .empty(fifo_empty)
    );

    //////////////////////////////////////////////////
    // readout side
    readout_ctrl #(.CBUF_AW(CBUF_AW)) u_ctrl (
        .adc_clk, .rst_n, .fifo_empty, .trig_addr,
        .pre_trig(async_pre_trig), .num_bursts(async_num_bursts),
        .initial_fill_num, .fill_num_load,
        .fifo_pop, .rd_addr, .gather, .sel_hdr, .out_valid, .fill_num,
        .acq_done, .sm_idle(adc_acq_sm_idle)
    );

    word_assembler u_asm (
        .adc_clk, .rst_n, .rd_pair, .gather, .sel_hdr, .out_valid, .fill_num, .channel_tag,
        .num_bursts(async_num_bursts), .pre_trig(async_pre_trig),
        .adc_acq_out_dat, .adc_acq_out_valid
    );

endmodule

`default_nettype wire

// File: tb_adc_acq_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adc_acq_top;

    localparam int          CBUF_AW = 10;              // small buffer of 1024 pairs
    localparam logic [31:0] SEED    = 32'hafd85d4b;
    localparam int          REAL_N  = 4;
    localparam int          REAL_PRE     [REAL_N] = '{0, 5, 37, 100};
    localparam int          REAL_BURSTS  [REAL_N] = '{1, 3, 8, 5};
    localparam int          DUMMY_PRE    [2]      = '{9, 0};
    localparam int          DUMMY_BURSTS [2]      = '{4, 2};
    localparam int          B2B_PRE    = 12;           // back to back fills
    localparam int          B2B_BURSTS = 6;

    logic                                adc_clk = 1'b0;
    logic                                rst_n;
    logic [adc_acq_pkg::SAMPLE_W-1:0]    adc_dat_a, adc_dat_b;
    logic                                adc_ovr_a, adc_ovr_b;
    logic [adc_acq_pkg::CHAN_TAG_W-1:0]  channel_tag;
    logic [adc_acq_pkg::FILL_NUM_W-1:0]  initial_fill_num, fill_num;
    logic                                initial_fill_num_wr, acq_enable0, acq_enable1, acq_trig;
    logic [adc_acq_pkg::BURST_W-1:0]     async_num_bursts;
    logic [adc_acq_pkg::PRE_TRIG_W-1:0]  async_pre_trig;
    logic                                acq_enabled, adc_acq_out_valid, acq_done, adc_acq_sm_idle;
    logic [adc_acq_pkg::OUT_W-1:0]       adc_acq_out_dat;

    int          cyc = 0;                // rising edges so far
    int          err_cnt = 0;
    int          fills_done = 0;
    logic [23:0] exp_fill_num = '0;
    int          q_seq[$], q_pre[$], q_bursts[$], q_tag[$];   // one entry per pending fill
    logic        in_fill = 1'b0;
    logic        fn_pending = 1'b0;      // check fill_num one cycle after acq_done
    int          words_left = 0;
    int          word_idx, f_seq, f_pre, f_bursts, f_tag;
    logic [11:0] prev_first;
    logic        prev_ok;

    adc_acq_top #(.CBUF_AW(CBUF_AW), .FIFO_AW(3)) u_adc_acq_top (.*);

    always #10 adc_clk = ~adc_clk;       // 20 ns period
    always @(posedge adc_clk) cyc <= cyc + 1;

    //////////////////////////////////////////////////
    // reference model
    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // pair sampled at edge s in {smp1, ovr1, smp0, ovr0} order
    function automatic logic [25:0] pair_of(int s);
        logic [31:0] x;
        logic [25:0] p;
        x        = xorshift32(SEED ^ s);
        p[0]     = x[12];
        p[12:1]  = s[11:0];              // first sample is the sequence number
        p[13]    = x[13];
        p[25:14] = x[11:0];
        return p;
    endfunction

    function automatic logic [131:0] ref_word(int trig_seq, int pre, int widx);
        logic [127:0] body;
        body = '0;
        for (int j = 0; j < 4; j++) body[j*26 +: 26] = pair_of(trig_seq - pre + 4*widx + j);
        return {4'(adc_acq_pkg::TAG_DATA), body};
    endfunction

    function automatic logic [131:0] hdr_word(logic [23:0] fnum, int tag, int bursts, int pre);
        logic [127:0] body;
        body        = '0;
        body[23:0]  = fnum;
        body[35:24] = tag[11:0];
        body[49:36] = bursts[13:0];
        body[65:50] = pre[15:0];
        return {4'(adc_acq_pkg::TAG_FILL_HDR), body};
    endfunction

    task automatic check_eq(string what, logic [131:0] got, logic [131:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus helpers
    task automatic tick(int n);
        repeat (n) @(posedge adc_clk);
        #2;                              // inputs change 2 ns after the edge
    endtask

    task automatic drive_pins(int s);
        logic [31:0] x;
        x = xorshift32(SEED ^ s);
        adc_dat_a = s[11:0];
        adc_dat_b = x[11:0];
        adc_ovr_a = x[12];
        adc_ovr_b = x[13];
    endtask

    // pin pair carries the index of the edge that samples it
    always @(posedge adc_clk) begin
        #2;
        drive_pins(cyc + 1);
    end

    task automatic fire_trigger();
        q_seq.push_back(cyc + 3);        // sampled at edge E with the trigger pair at E+2
        q_pre.push_back(async_pre_trig);
        q_bursts.push_back(async_num_bursts);
        q_tag.push_back(channel_tag);
        acq_trig = 1'b1;
        tick(2);
        acq_trig = 1'b0;
        tick(2);
    endtask

    task automatic wait_fills(int n);
        while (fills_done < n) tick(1);
    endtask

    task automatic run_fill(int pre, int bursts);
        int target;
        target           = fills_done + 1;
        async_pre_trig   = pre[15:0];
        async_num_bursts = bursts[13:0];
        fire_trigger();
        wait_fills(target);
    endtask

    //////////////////////////////////////////////////
    // compare outputs on the falling edge where they are stable
    always @(negedge adc_clk) begin
        logic [25:0] p;
        if (rst_n) begin
            check_eq("acq_done timing", acq_done,
                     adc_acq_out_valid && in_fill && words_left == 1);
            if (fn_pending) begin
                check_eq("fill_num after acq_done", fill_num, exp_fill_num);
                fn_pending = 1'b0;
            end
            if (adc_acq_out_valid && !in_fill) begin   // header opens a fill
                check_eq("trigger pending at header", q_seq.size() > 0, 1'b1);
                f_seq    = q_seq.pop_front();
                f_pre    = q_pre.pop_front();
                f_bursts = q_bursts.pop_front();
                f_tag    = q_tag.pop_front();
                check_eq("fill header", adc_acq_out_dat,
                         hdr_word(exp_fill_num, f_tag, f_bursts, f_pre));
                in_fill    = 1'b1;
                words_left = f_bursts;
                word_idx   = 0;
                prev_ok    = 1'b0;
            end else if (adc_acq_out_valid) begin
                check_eq("data tag and pad", adc_acq_out_dat[131:104],
                         {4'(adc_acq_pkg::TAG_DATA), 24'h0});
                if (f_tag[3]) begin      // counter data
                    for (int j = 0; j < 4; j++) begin
                        p = adc_acq_out_dat[j*26 +: 26];
                        check_eq("dummy second sample", p[25:14], 12'(p[12:1] + 12'd1));
                        check_eq("dummy over-range bits", {p[13], p[0]}, 2'b00);
                        if (prev_ok) begin
                            check_eq("dummy first sample step", p[12:1],
                                     12'(prev_first + 12'd2));
                        end
                        prev_first = p[12:1];
                        prev_ok    = 1'b1;
                    end
                end else begin
                    check_eq("data word", adc_acq_out_dat, ref_word(f_seq, f_pre, word_idx));
                end
                word_idx++;
                words_left--;
                if (words_left == 0) begin   // fill complete
                    in_fill    = 1'b0;
                    fn_pending = 1'b1;
                    exp_fill_num++;
                    fills_done++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    initial begin
        int target;
        rst_n               = 1'b0;
        channel_tag         = 12'h5a1;   // bit 3 clear selects real data
        initial_fill_num    = '0;
        initial_fill_num_wr = 1'b0;
        acq_enable0         = 1'b0;
        acq_enable1         = 1'b0;
        acq_trig            = 1'b0;
        async_num_bursts    = 14'd1;
        async_pre_trig      = '0;
        drive_pins(1);
        repeat (10) @(posedge adc_clk);
        #2;
        rst_n = 1'b1;
        tick(2);
        check_eq("acq_enabled after reset", acq_enabled, 1'b0);
        check_eq("out_valid after reset", adc_acq_out_valid, 1'b0);
        check_eq("acq_done after reset", acq_done, 1'b0);
        check_eq("sm_idle after reset", adc_acq_sm_idle, 1'b1);
        initial_fill_num    = 24'h3a5c71;
        initial_fill_num_wr = 1'b1;
        tick(2);
        initial_fill_num_wr = 1'b0;
        tick(3);
        exp_fill_num = 24'h3a5c71;
        check_eq("loaded fill_num", fill_num, 24'h3a5c71);
        acq_enable1 = 1'b1;              // either enable starts writing
        tick(3);
        check_eq("acq_enabled", acq_enabled, 1'b1);
        tick(150);                       // history for the largest pre-trigger
        for (int i = 0; i < REAL_N; i++) run_fill(REAL_PRE[i], REAL_BURSTS[i]);
        channel_tag[3] = 1'b1;
        tick(40);
        for (int i = 0; i < 2; i++) run_fill(DUMMY_PRE[i], DUMMY_BURSTS[i]);
        channel_tag[3] = 1'b0;
        acq_enable0    = 1'b1;
        tick(40);
        target           = fills_done + 2;
        async_pre_trig   = B2B_PRE;
        async_num_bursts = B2B_BURSTS;
        fire_trigger();
        tick(6);
        fire_trigger();                  // first fill still reading
        check_eq("sm busy between triggers", adc_acq_sm_idle, 1'b0);
        wait_fills(target);
        tick(3);
        check_eq("sm_idle after fills", adc_acq_sm_idle, 1'b1);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "errors seen");
        end
    end

    // watchdog scaled with the number of bursts requested
    initial begin
        int limit;
        limit = 2000 + 10 * (REAL_BURSTS.sum() + DUMMY_BURSTS.sum() + 2 * B2B_BURSTS);
        repeat (limit) @(posedge adc_clk);
        $display("watchdog expired after %0d cycles, fills did not complete", limit);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: adc_acq_top.f
adc_acq_pkg.sv
acq_input_sync.sv
sample_source.sv
circ_buf_ram.sv
trig_addr_fifo.sv
readout_ctrl.sv
word_assembler.sv
adc_acq_top.sv
tb_adc_acq_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the adc_acq_top testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_acq_top \
    -f adc_acq_top.f -o sim_adc_acq
./obj_dir/sim_adc_acq > sim.log 2>&1 || true
cat sim.log
if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
